//--- src/wb_xbar_pkg.sv
// Wishbone multicast interconnect package with widths, the fixed address map and FSM states
package wb_xbar_pkg;

  // Bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned SEL_W  = DATA_W / 8;

  // Target ports behind the interconnect
  localparam int unsigned NUM_TARGETS = 4;
  localparam int unsigned TGT_IDX_W   = $clog2(NUM_TARGETS);

  // Address, multicast mask, base and region mask all share this width
  typedef logic [ADDR_W-1:0] adr_t;

  // Write and read data words
  typedef logic [DATA_W-1:0] dat_t;

  // Byte lane select
  typedef logic [SEL_W-1:0] sel_t;

  // One bit per target port
  typedef logic [NUM_TARGETS-1:0] tgt_mask_t;

  // Index of a single target port
  typedef logic [TGT_IDX_W-1:0] tgt_idx_t;

  // Base address of each target, index 0 in the lowest slot
  localparam adr_t [NUM_TARGETS-1:0] TGT_BASE = {
    32'h0000_3000,
    32'h0000_2000,
    32'h0000_1000,
    32'h0000_0000
  };

  // Offset bits inside one 4 KiB region
  // These bits never take part in target selection
  localparam adr_t TGT_REGION_MASK = 32'h0000_0FFF;

  // Exclusive end of each target region
  localparam adr_t [NUM_TARGETS-1:0] TGT_END = {
    32'h0000_4000,
    32'h0000_3000,
    32'h0000_2000,
    32'h0000_1000
  };

  // Fan-out controller states
  //   FAN_IDLE  waiting for a request, or finishing one in its first cycle
  //   FAN_BUSY  request issued, some selected targets still owe an ack
  //   FAN_ERR   decode error, err is returned for this one cycle
  typedef enum logic [1:0] {
    FAN_IDLE,
    FAN_BUSY,
    FAN_ERR
  } fanout_state_t;

endpackage

//--- src/wb_mcast_decode.sv
// Multicast write decoder that maps an address and a multicast mask onto a target select mask
`timescale 1ns/1ns

module wb_mcast_decode (
  input  wb_xbar_pkg::adr_t      adr_i,
  input  wb_xbar_pkg::adr_t      mcast_mask_i,
  output wb_xbar_pkg::tgt_mask_t select_o
);

  // Bits that must agree with a target's base address
  // A bit set in the request mask or inside the region is a don't-care
  wb_xbar_pkg::adr_t care_mask;

  // Per-target mismatch vectors, restricted to the cared-for bits
  wb_xbar_pkg::adr_t [wb_xbar_pkg::NUM_TARGETS-1:0] diff;

  assign care_mask = ~(mcast_mask_i | wb_xbar_pkg::TGT_REGION_MASK);

  for (genvar t = 0; t < wb_xbar_pkg::NUM_TARGETS; t++) begin : gen_match
    // Bits where the address and the base differ and that still count
    assign diff[t] = (adr_i ^ wb_xbar_pkg::TGT_BASE[t]) & care_mask;

    // Target is hit when nothing relevant differs
    assign select_o[t] = (diff[t] == '0);
  end

  // Examples with the default map
  //   adr 0x0000_0010, mask 0x0000_0000 -> target 0 only
  //   adr 0x0000_0010, mask 0x0000_1000 -> targets 0 and 1
  //   adr 0x0000_0010, mask 0x0000_3000 -> all four targets
  //   adr 0x0000_4010, mask 0x0000_0000 -> none, a write decode error
  // The caller treats an all-zero select_o as the error case

endmodule

//--- src/wb_read_decode.sv
// Interval read decoder that maps an address onto one target index and a hit flag
`timescale 1ns/1ns

module wb_read_decode (
  input  wb_xbar_pkg::adr_t    adr_i,
  output wb_xbar_pkg::tgt_idx_t index_o,
  output logic                  hit_o
);

  // One flag per target whose half-open interval holds the address
  wb_xbar_pkg::tgt_mask_t in_range;

  for (genvar t = 0; t < wb_xbar_pkg::NUM_TARGETS; t++) begin : gen_range
    assign in_range[t] = (adr_i >= wb_xbar_pkg::TGT_BASE[t]) &&
                         (adr_i <  wb_xbar_pkg::TGT_END[t]);
  end

  // Any interval hit at all
  assign hit_o = |in_range;

  // Priority encoder, lowest matching index wins
  // Walk from the top so a lower hit overrides a higher one
  always_comb begin
    index_o = '0;
    for (int i = wb_xbar_pkg::NUM_TARGETS - 1; i >= 0; i--) begin
      if (in_range[i]) begin
        index_o = wb_xbar_pkg::tgt_idx_t'(i);
      end
    end
  end

  // With the default map the intervals do not overlap
  // Index is don't-care when hit_o is low

endmodule

//--- src/wb_mcast_fanout.sv
// Fan-out controller that strobes the selected targets, collects acks and answers the initiator
`timescale 1ns/1ns

module wb_mcast_fanout (
  input  logic                                            clk_i,
  input  logic                                            rst_n_i,
  // Initiator request
  input  logic                                            cyc_i,
  input  logic                                            stb_i,
  input  logic                                            we_i,
  // Decoder results
  input  wb_xbar_pkg::tgt_mask_t                          wr_select_i,
  input  wb_xbar_pkg::tgt_idx_t                           rd_index_i,
  input  logic                                            rd_hit_i,
  // Target responses
  input  wb_xbar_pkg::tgt_mask_t                          tgt_ack_i,
  input  wb_xbar_pkg::dat_t [wb_xbar_pkg::NUM_TARGETS-1:0] tgt_dat_i,
  // Initiator response
  output logic                                            ack_o,
  output logic                                            err_o,
  output wb_xbar_pkg::dat_t                               dat_o,
  // Target strobes
  output wb_xbar_pkg::tgt_mask_t                          tgt_cyc_o,
  output wb_xbar_pkg::tgt_mask_t                          tgt_stb_o,
  output wb_xbar_pkg::tgt_mask_t                          tgt_we_o
);

  wb_xbar_pkg::fanout_state_t state_q;
  wb_xbar_pkg::fanout_state_t state_d;

  // Targets that already acked the current write
  wb_xbar_pkg::tgt_mask_t acked_q;
  wb_xbar_pkg::tgt_mask_t acked_d;

  wb_xbar_pkg::tgt_mask_t rd_onehot;
  wb_xbar_pkg::tgt_mask_t target_mask;
  wb_xbar_pkg::tgt_mask_t pending;
  wb_xbar_pkg::tgt_mask_t acked_now;

  logic req;
  logic active;
  logic no_target;
  logic done;

  assign req = cyc_i & stb_i;

  // Reads go to a single target, only when the interval decoder hit
  assign rd_onehot = rd_hit_i ? (wb_xbar_pkg::tgt_mask_t'(1) << rd_index_i) : '0;

  // The one place where we_i picks between the two decoders
  assign target_mask = we_i ? wr_select_i : rd_onehot;
  assign no_target   = (target_mask == '0);

  // No target is touched while the error cycle is returned
  assign active = req & (state_q != wb_xbar_pkg::FAN_ERR);

  // Selected targets still owing an ack
  assign pending = target_mask & ~acked_q;

  // Acks seen so far including this cycle
  assign acked_now = acked_q | (tgt_ack_i & pending);

  // Last outstanding ack arrives in this cycle
  assign done = active & ~no_target & ((acked_now & target_mask) == target_mask);

  // Target side
  assign tgt_cyc_o = active ? target_mask : '0;
  assign tgt_stb_o = active ? pending : '0;
  assign tgt_we_o  = tgt_cyc_o & {wb_xbar_pkg::NUM_TARGETS{we_i}};

  // Initiator side
  assign ack_o = done;
  assign err_o = (state_q == wb_xbar_pkg::FAN_ERR);
  assign dat_o = tgt_dat_i[rd_index_i];

  always_comb begin
    state_d = state_q;
    acked_d = acked_q;
    case (state_q)
      wb_xbar_pkg::FAN_IDLE: begin
        if (req) begin
          if (no_target) begin
            state_d = wb_xbar_pkg::FAN_ERR;
          end else if (done) begin
            // Single-cycle completion, nothing to remember
            acked_d = '0;
          end else begin
            state_d = wb_xbar_pkg::FAN_BUSY;
            acked_d = acked_now;
          end
        end
      end
      wb_xbar_pkg::FAN_BUSY: begin
        if (!req || done) begin
          // Completed, or the initiator gave up the cycle
          state_d = wb_xbar_pkg::FAN_IDLE;
          acked_d = '0;
        end else begin
          acked_d = acked_now;
        end
      end
      wb_xbar_pkg::FAN_ERR: begin
        // err is held for exactly this one cycle
        state_d = wb_xbar_pkg::FAN_IDLE;
        acked_d = '0;
      end
      default: begin
        state_d = wb_xbar_pkg::FAN_IDLE;
        acked_d = '0;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= wb_xbar_pkg::FAN_IDLE;
      acked_q <= '0;
    end else begin
      state_q <= state_d;
      acked_q <= acked_d;
    end
  end

endmodule

//--- src/wb_mcast_xbar.sv
// Wishbone classic multicast interconnect with one initiator port and four target ports
`timescale 1ns/1ns

module wb_mcast_xbar (
  input  logic                                            clk_i,
  input  logic                                            rst_n_i,
  // Initiator port
  input  logic                                            cyc_i,
  input  logic                                            stb_i,
  input  logic                                            we_i,
  input  wb_xbar_pkg::adr_t                               adr_i,
  input  wb_xbar_pkg::dat_t                               dat_i,
  input  wb_xbar_pkg::sel_t                               sel_i,
  input  wb_xbar_pkg::adr_t                               mcast_mask_i,
  output wb_xbar_pkg::dat_t                               dat_o,
  output logic                                            ack_o,
  output logic                                            err_o,
  // Target ports
  output wb_xbar_pkg::tgt_mask_t                          tgt_cyc_o,
  output wb_xbar_pkg::tgt_mask_t                          tgt_stb_o,
  output wb_xbar_pkg::tgt_mask_t                          tgt_we_o,
  output wb_xbar_pkg::adr_t                               tgt_adr_o,
  output wb_xbar_pkg::dat_t                               tgt_dat_o,
  output wb_xbar_pkg::sel_t                               tgt_sel_o,
  input  wb_xbar_pkg::tgt_mask_t                          tgt_ack_i,
  input  wb_xbar_pkg::dat_t [wb_xbar_pkg::NUM_TARGETS-1:0] tgt_dat_i
);

  wb_xbar_pkg::tgt_mask_t wr_select;
  wb_xbar_pkg::tgt_idx_t  rd_index;
  logic                   rd_hit;

  // Every target sees the request fields unchanged
  assign tgt_adr_o = adr_i;
  assign tgt_dat_o = dat_i;
  assign tgt_sel_o = sel_i;

  // Write path decode, address plus multicast mask
  wb_mcast_decode u_mcast_decode (
    .adr_i       (adr_i),
    .mcast_mask_i(mcast_mask_i),
    .select_o    (wr_select)
  );

  // Read path decode, interval match on the address alone
  wb_read_decode u_read_decode (
    .adr_i  (adr_i),
    .index_o(rd_index),
    .hit_o  (rd_hit)
  );

  wb_mcast_fanout u_fanout (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .cyc_i      (cyc_i),
    .stb_i      (stb_i),
    .we_i       (we_i),
    .wr_select_i(wr_select),
    .rd_index_i (rd_index),
    .rd_hit_i   (rd_hit),
    .tgt_ack_i  (tgt_ack_i),
    .tgt_dat_i  (tgt_dat_i),
    .ack_o      (ack_o),
    .err_o      (err_o),
    .dat_o      (dat_o),
    .tgt_cyc_o  (tgt_cyc_o),
    .tgt_stb_o  (tgt_stb_o),
    .tgt_we_o   (tgt_we_o)
  );

endmodule

//--- tests/wb_target_model.sv
// Wishbone target model with a 16-word memory and a random ack delay of 0 to 3 cycles
`timescale 1ns/1ns

module wb_target_model #(
  parameter int unsigned TGT_ID = 0
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              cyc_i,
  input  logic              stb_i,
  input  logic              we_i,
  input  wb_xbar_pkg::adr_t adr_i,
  input  wb_xbar_pkg::dat_t dat_i,
  input  wb_xbar_pkg::sel_t sel_i,
  output logic              ack_o,
  output wb_xbar_pkg::dat_t dat_o,
  output int unsigned       wr_count_o
);

  localparam logic [31:0] SEED = 32'hf3ca_a018;

  wb_xbar_pkg::dat_t mem [16];
  logic [31:0]       rng_q;
  logic [1:0]        wait_q;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Ack once the strobe has waited the drawn number of cycles
  assign ack_o = cyc_i & stb_i & (wait_q == rng_q[1:0]);
  assign dat_o = mem[adr_i[5:2]];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wait_q     <= '0;
      rng_q      <= SEED ^ TGT_ID;
      wr_count_o <= 0;
      // Fill word holds the byte address of the word in the map
      for (int w = 0; w < 16; w++) begin
        mem[w] <= 32'hc0de_0000 | (TGT_ID << 12) | (w << 2);
      end
    end else if (cyc_i && stb_i) begin
      if (ack_o) begin
        wait_q <= '0;
        rng_q  <= xorshift(rng_q);
        if (we_i) begin
          for (int b = 0; b < 4; b++) begin
            if (sel_i[b]) begin
              mem[adr_i[5:2]][8*b +: 8] <= dat_i[8*b +: 8];
            end
          end
          wr_count_o <= wr_count_o + 1;
        end
      end else begin
        wait_q <= wait_q + 2'd1;
      end
    end else begin
      wait_q <= '0;
    end
  end

endmodule

//--- tests/wb_mcast_xbar_tb.sv
// Testbench for the Wishbone multicast interconnect with four memory targets
`timescale 1ns/1ns

module wb_mcast_xbar_tb;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 4;
  localparam int NUM_ENTRIES  = 34;
  localparam int MAX_WAIT     = 8;
  localparam int WATCHDOG_NS  = (NUM_ENTRIES * 10 + RESET_CYCLES + 4) * CLK_PERIOD;
  localparam logic OP_WR = 1'b1;
  localparam logic OP_RD = 1'b0;

  typedef struct packed {
    logic              we;
    wb_xbar_pkg::adr_t adr;
    wb_xbar_pkg::adr_t mask;
    wb_xbar_pkg::dat_t wdata;
    logic              exp_err;
  } entry_t;

  logic                        clk;
  logic                        rst_n;
  logic                        cyc;
  logic                        stb;
  logic                        we;
  wb_xbar_pkg::adr_t           adr;
  wb_xbar_pkg::dat_t           wdat;
  wb_xbar_pkg::sel_t           sel;
  wb_xbar_pkg::adr_t           mcast_mask;
  wb_xbar_pkg::dat_t           dat_o;
  logic                        ack_o;
  logic                        err_o;
  wb_xbar_pkg::tgt_mask_t      tgt_cyc;
  wb_xbar_pkg::tgt_mask_t      tgt_stb;
  wb_xbar_pkg::tgt_mask_t      tgt_we;
  wb_xbar_pkg::adr_t           tgt_adr;
  wb_xbar_pkg::dat_t           tgt_dat;
  wb_xbar_pkg::sel_t           tgt_sel;
  wb_xbar_pkg::tgt_mask_t      tgt_ack;
  wb_xbar_pkg::dat_t [3:0]     tgt_rdat;
  int unsigned                 wr_count [4];

  // Reference state
  entry_t                      tbl [NUM_ENTRIES];
  int                          n_entries;
  wb_xbar_pkg::dat_t           shadow [4][16];
  int unsigned                 exp_writes [4];
  int                          ack_errors;
  int                          err_errors;
  int                          data_errors;
  int                          mask_errors;
  int                          count_errors;
  int                          other_errors;

  wb_mcast_xbar UUT (
    .clk_i(clk), .rst_n_i(rst_n), .cyc_i(cyc), .stb_i(stb), .we_i(we),
    .adr_i(adr), .dat_i(wdat), .sel_i(sel), .mcast_mask_i(mcast_mask),
    .dat_o(dat_o), .ack_o(ack_o), .err_o(err_o),
    .tgt_cyc_o(tgt_cyc), .tgt_stb_o(tgt_stb), .tgt_we_o(tgt_we),
    .tgt_adr_o(tgt_adr), .tgt_dat_o(tgt_dat), .tgt_sel_o(tgt_sel),
    .tgt_ack_i(tgt_ack), .tgt_dat_i(tgt_rdat)
  );

  for (genvar t = 0; t < 4; t++) begin : gen_tgt
    wb_target_model #(.TGT_ID(t)) u_tgt (
      .clk_i(clk), .rst_n_i(rst_n), .cyc_i(tgt_cyc[t]), .stb_i(tgt_stb[t]),
      .we_i(tgt_we[t]), .adr_i(tgt_adr), .dat_i(tgt_dat), .sel_i(tgt_sel),
      .ack_o(tgt_ack[t]), .dat_o(tgt_rdat[t]), .wr_count_o(wr_count[t])
    );
  end

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  task automatic check_ack(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s ack_o is %b, expected %b", $time, what, got, exp);
      ack_errors++;
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s err_o is %b, expected %b", $time, what, got, exp);
      err_errors++;
    end
  endtask

  task automatic check_data(input wb_xbar_pkg::dat_t got, input wb_xbar_pkg::dat_t exp,
                            input string what);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s data is %h, expected %h", $time, what, got, exp);
      data_errors++;
    end
  endtask

  task automatic check_mask(input wb_xbar_pkg::tgt_mask_t got,
                            input wb_xbar_pkg::tgt_mask_t exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      mask_errors++;
    end
  endtask

  task automatic check_count(input int unsigned got, input int unsigned exp, input string what);
    if (got != exp) begin
      $display("FAILED at %0t ns: %s write count is %0d, expected %0d", $time, what, got, exp);
      count_errors++;
    end
  endtask

  // Targets a request should reach, from the address map rules
  function automatic wb_xbar_pkg::tgt_mask_t expected_select(input entry_t e);
    wb_xbar_pkg::tgt_mask_t hit;
    wb_xbar_pkg::adr_t      base;
    wb_xbar_pkg::adr_t      region;
    hit = '0;
    region = 32'h0000_0fff;
    for (int t = 0; t < 4; t++) begin
      base = wb_xbar_pkg::adr_t'(t) << 12;
      if (e.we) begin
        // A write misses on any bit outside both masks where address and base differ
        hit[t] = 1'b1;
        for (int b = 0; b < 32; b++) begin
          if (!e.mask[b] && !region[b] && (e.adr[b] != base[b])) begin
            hit[t] = 1'b0;
          end
        end
      end else begin
        // Each read region is one aligned 4 KiB page
        hit[t] = (e.adr[31:12] == base[31:12]);
      end
    end
    return hit;
  endfunction

  task automatic add_entry(input logic op, input wb_xbar_pkg::adr_t a,
                           input wb_xbar_pkg::adr_t m, input wb_xbar_pkg::dat_t d,
                           input logic exp_err);
    if (n_entries < NUM_ENTRIES) begin
      tbl[n_entries] = '{op, a, m, d, exp_err};
    end
    n_entries++;
  endtask

  // Drive one request on the falling edge and wait for ack or err
  // Strobes and ack follow the targets that have answered so far
  task automatic run_request(input int i, input entry_t e, input wb_xbar_pkg::tgt_mask_t hit,
                             output logic got_ack, output logic got_err,
                             output wb_xbar_pkg::dat_t got_dat);
    int                     waited;
    wb_xbar_pkg::tgt_mask_t seen;
    @(negedge clk);
    cyc = 1'b1;
    stb = 1'b1;
    we = e.we;
    adr = e.adr;
    mcast_mask = e.mask;
    wdat = e.wdata;
    got_ack = 1'b0;
    got_err = 1'b0;
    got_dat = '0;
    waited = 0;
    seen = '0;
    while (!got_ack && !got_err && waited < MAX_WAIT) begin
      #(CLK_PERIOD/4);
      got_ack = ack_o;
      got_err = err_o;
      got_dat = dat_o;
      check_mask(tgt_cyc, hit, $sformatf("entry %0d tgt_cyc_o", i));
      check_mask(tgt_stb, hit & ~seen, $sformatf("entry %0d tgt_stb_o", i));
      check_mask(tgt_we, e.we ? hit : '0, $sformatf("entry %0d tgt_we_o", i));
      seen = seen | (tgt_ack & hit);
      if (e.exp_err) begin
        // Error answer comes one cycle after the request
        check_err(err_o, waited == 1, $sformatf("entry %0d cycle %0d,", i, waited));
      end else begin
        check_ack(ack_o, (seen & hit) == hit, $sformatf("entry %0d cycle %0d,", i, waited));
      end
      @(negedge clk);
      waited++;
    end
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    // Response lasts a single cycle
    #(CLK_PERIOD/4);
    check_ack(ack_o, 1'b0, $sformatf("entry %0d after end,", i));
    check_err(err_o, 1'b0, $sformatf("entry %0d after end,", i));
  endtask

  task automatic apply_entry(input int i);
    entry_t                 e;
    wb_xbar_pkg::tgt_mask_t hit;
    logic                   got_ack;
    logic                   got_err;
    wb_xbar_pkg::dat_t      got_dat;
    e = tbl[i];
    hit = expected_select(e);
    run_request(i, e, hit, got_ack, got_err, got_dat);
    if (!got_ack && !got_err) begin
      $display("Entry %0d got neither ack nor err within %0d cycles", i, MAX_WAIT);
      other_errors++;
    end else begin
      check_ack(got_ack, ~e.exp_err, $sformatf("entry %0d", i));
      check_err(got_err, e.exp_err, $sformatf("entry %0d", i));
    end
    for (int t = 0; t < 4; t++) begin
      if (hit[t] && e.we && !e.exp_err) begin
        shadow[t][e.adr[5:2]] = e.wdata;
        exp_writes[t]++;
      end
      if (hit[t] && !e.we && !e.exp_err) begin
        check_data(got_dat, shadow[t][e.adr[5:2]], $sformatf("entry %0d read", i));
      end
      check_count(wr_count[t], exp_writes[t], $sformatf("entry %0d target %0d", i, t));
    end
  endtask

  function automatic int total_errors();
    return ack_errors + err_errors + data_errors + mask_errors + count_errors + other_errors;
  endfunction

  initial begin
    rst_n = 1'b0;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    wdat = '0;
    sel = '1;
    mcast_mask = '0;
    n_entries = 0;
    ack_errors = 0;
    err_errors = 0;
    data_errors = 0;
    mask_errors = 0;
    count_errors = 0;
    other_errors = 0;
    for (int t = 0; t < 4; t++) begin
      exp_writes[t] = 0;
      for (int w = 0; w < 16; w++) begin
        shadow[t][w] = 32'hc0de_0000 | (t << 12) | (w << 2);
      end
    end

    // Unicast write and read back per target
    add_entry(OP_WR, 32'h0000_0010, 32'h0000_0000, 32'h1111_0001, 1'b0);
    add_entry(OP_RD, 32'h0000_0010, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_entry(OP_WR, 32'h0000_1014, 32'h0000_0000, 32'h2222_0002, 1'b0);
    add_entry(OP_RD, 32'h0000_1014, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_entry(OP_WR, 32'h0000_2018, 32'h0000_0000, 32'h3333_0003, 1'b0);
    add_entry(OP_RD, 32'h0000_2018, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_entry(OP_WR, 32'h0000_303c, 32'h0000_0000, 32'h4444_0004, 1'b0);
    add_entry(OP_RD, 32'h0000_303c, 32'h0000_0000, 32'h0000_0000, 1'b0);
    // Broadcast to all four, then a write that hits targets 0 and 1
    add_entry(OP_WR, 32'h0000_0020, 32'h0000_3000, 32'ha5a5_0020, 1'b0);
    add_entry(OP_RD, 32'h0000_0020, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_entry(OP_RD, 32'h0000_1020, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_entry(OP_RD, 32'h0000_2020, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_entry(OP_RD, 32'h0000_3020, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_entry(OP_WR, 32'h0000_1024, 32'h0000_1000, 32'h5a5a_0024, 1'b0);
    add_entry(OP_RD, 32'h0000_0024, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_entry(OP_RD, 32'h0000_1024, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_entry(OP_RD, 32'h0000_2024, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_entry(OP_RD, 32'h0000_3024, 32'h0000_0000, 32'h0000_0000, 1'b0);
    // Decode errors, then reads that show nothing changed
    add_entry(OP_RD, 32'h0000_4000, 32'h0000_0000, 32'h0000_0000, 1'b1);
    add_entry(OP_WR, 32'h0000_4010, 32'h0000_0000, 32'hdead_4010, 1'b1);
    add_entry(OP_RD, 32'h8000_0010, 32'h0000_0000, 32'h0000_0000, 1'b1);
    add_entry(OP_WR, 32'hffff_f020, 32'h0000_0000, 32'hdead_f020, 1'b1);
    add_entry(OP_RD, 32'h0000_0010, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_entry(OP_RD, 32'h0000_0020, 32'h0000_0000, 32'h0000_0000, 1'b0);
    // Back to back multicast writes under random ack delays
    add_entry(OP_WR, 32'h0000_0030, 32'h0000_3000, 32'h0bad_0030, 1'b0);
    add_entry(OP_WR, 32'h0000_2030, 32'h0000_3000, 32'h600d_0030, 1'b0);
    add_entry(OP_WR, 32'h0000_3034, 32'h0000_2000, 32'h7777_0034, 1'b0);
    add_entry(OP_RD, 32'h0000_0030, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_entry(OP_RD, 32'h0000_1030, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_entry(OP_RD, 32'h0000_2030, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_entry(OP_RD, 32'h0000_3030, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_entry(OP_RD, 32'h0000_1034, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_entry(OP_RD, 32'h0000_3034, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_entry(OP_RD, 32'h0000_0034, 32'h0000_0000, 32'h0000_0000, 1'b0);
    if (n_entries != NUM_ENTRIES) begin
      $display("Stimulus table holds %0d entries instead of %0d", n_entries, NUM_ENTRIES);
      other_errors++;
    end

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #(CLK_PERIOD/4);
    check_ack(ack_o, 1'b0, "after reset");
    check_err(err_o, 1'b0, "after reset");
    check_mask(tgt_cyc, '0, "after reset tgt_cyc_o");
    check_mask(tgt_stb, '0, "after reset tgt_stb_o");

    for (int i = 0; i < NUM_ENTRIES && i < n_entries; i++) begin
      apply_entry(i);
    end

    $display("Errors: ack %0d, err %0d, data %0d, strobe %0d, count %0d, other %0d",
             ack_errors, err_errors, data_errors, mask_errors, count_errors, other_errors);
    if (total_errors() == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- verilog.f
src/wb_xbar_pkg.sv
src/wb_mcast_decode.sv
src/wb_read_decode.sv
src/wb_mcast_fanout.sv
src/wb_mcast_xbar.sv
tests/wb_target_model.sv
tests/wb_mcast_xbar_tb.sv

//--- run.sh
#!/bin/sh
# Build the multicast interconnect testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
TOP=wb_mcast_xbar_tb

verilator --binary --timing \
  -f verilog.f \
  --top-module "$TOP" \
  -Mdir "$BUILD_DIR" \
  -o sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$("./$BUILD_DIR/sim")
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST RESULT: PASS"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1
